// File: hw/lfsr_tx_pkg.sv
package lfsr_tx_pkg;

    localparam int NUM_GEN_LANES = 8;
    localparam int NUM_TX_LANES  = 16;

    typedef logic [31:0] lane_word_t;
    typedef logic [22:0] prbs_state_t;
    typedef logic [3:0]  lane_idx_t;

    typedef enum logic [1:0] {
        CMD_IDLE    = 2'd0,
        CMD_CLEAR   = 2'd1,
        CMD_PATTERN = 2'd2,
        CMD_LANE_ID = 2'd3
    } tx_cmd_e;

    typedef enum logic [1:0] {
        LANES_NONE  = 2'd0,
        LANES_0_7   = 2'd1,
        LANES_8_15  = 2'd2,
        LANES_0_15  = 2'd3
    } tx_lanes_e;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_CLEAR   = 2'd1,
        ST_PATTERN = 2'd2,
        ST_LANE_ID = 2'd3
    } tx_state_e;

    // Generator 0 first
    localparam prbs_state_t PRBS_SEEDS [NUM_GEN_LANES] = '{
        23'h1DBFBC, 23'h0607BB, 23'h1EC760, 23'h18C0DB,
        23'h010F12, 23'h19CFC9, 23'h0277CE, 23'h1BB807
    };

    localparam logic [3:0] LANE_ID_MARK = 4'b1010; // Framing nibble around each lane id

endpackage

// File: hw/lfsr_tx_ctrl.sv
module lfsr_tx_ctrl
    import lfsr_tx_pkg::*;
#(
    parameter int PATTERN_WORDS = 127,
    parameter int LANE_ID_WORDS = 63
)(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  tx_cmd_e   i_cmd,
    input  tx_lanes_e i_lanes,
    input  logic      i_enable_reversal,
    output logic      o_gen_clear,
    output logic      o_gen_advance,
    output logic      o_send_pattern,
    output logic      o_send_id,
    output logic      o_reversed,
    output logic      o_tx_done,
    output logic      o_enable_frame
);

    localparam int MAX_WORDS = (PATTERN_WORDS > LANE_ID_WORDS) ? PATTERN_WORDS : LANE_ID_WORDS;
    localparam int CNT_W     = $clog2(MAX_WORDS + 1);
    localparam logic [CNT_W-1:0] PAT_LAST = CNT_W'(PATTERN_WORDS);
    localparam logic [CNT_W-1:0] ID_LAST  = CNT_W'(LANE_ID_WORDS);

    tx_state_e        state;
    tx_cmd_e          cmd_q;
    logic [CNT_W-1:0] word_cnt;
    logic             cmd_start;
    logic             run_end;

    // A command counts only on a change, and only with some lanes enabled
    assign cmd_start = (i_cmd != cmd_q) && (i_cmd != CMD_IDLE) && (i_lanes != LANES_NONE);

    // Counter sits one past the last sent word
    assign run_end = ((state == ST_PATTERN) && (word_cnt == PAT_LAST)) ||
                     ((state == ST_LANE_ID) && (word_cnt == ID_LAST));

    assign o_gen_clear    = (state == ST_CLEAR);
    assign o_gen_advance  = (state == ST_PATTERN);
    assign o_send_pattern = (state == ST_PATTERN) && (word_cnt < PAT_LAST);
    assign o_send_id      = (state == ST_LANE_ID) && (word_cnt < ID_LAST);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= ST_IDLE;
            cmd_q    <= CMD_IDLE;
            word_cnt <= '0;
        end else begin
            cmd_q <= i_cmd;
            case (state)
                ST_IDLE: begin
                    word_cnt <= '0;
                    if (cmd_start) begin
                        case (i_cmd)
                            CMD_CLEAR:   state <= ST_CLEAR;
                            CMD_PATTERN: state <= ST_PATTERN;
                            CMD_LANE_ID: state <= ST_LANE_ID;
                            default:     state <= ST_IDLE;
                        endcase
                    end
                end
                ST_CLEAR: state <= ST_IDLE; // Single cycle, seeds reload at this edge
                default: begin
                    if (run_end) begin
                        state    <= ST_IDLE;
                        word_cnt <= '0;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_reversed     <= 1'b0;
            o_tx_done      <= 1'b0;
            o_enable_frame <= 1'b0;
        end else begin
            if ((state == ST_IDLE) && i_enable_reversal)
                o_reversed <= 1'b1; // Sticky until reset
            o_tx_done      <= run_end;
            o_enable_frame <= o_send_pattern || o_send_id;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state inside {ST_PATTERN, ST_LANE_ID}) |-> (i_lanes != LANES_NONE));

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_tx_done |=> !o_tx_done);

endmodule

// File: hw/prbs23_lane_gen.sv
module prbs23_lane_gen
    import lfsr_tx_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_clear,
    input  logic       i_advance,
    output lane_word_t o_gen_word [NUM_GEN_LANES]
);

    // x^23 + x^21 + x^16 + x^8 + x^5 + x^2 + 1
    localparam prbs_state_t TAP_MASK  = 23'h508092;
    localparam int          WORD_BITS = $bits(lane_word_t);

    prbs_state_t state      [NUM_GEN_LANES];
    prbs_state_t state_next [NUM_GEN_LANES];

    // Unrolled 32 bit-steps per generator, first bit lands in bit 0
    always_comb begin
        prbs_state_t s;
        lane_word_t  w;
        logic        fb;
        for (int g = 0; g < NUM_GEN_LANES; g++) begin
            s = state[g];
            w = '0;
            for (int b = 0; b < WORD_BITS; b++) begin
                fb   = ^(s & TAP_MASK);
                w[b] = fb;
                s    = {s[21:0], fb};
            end
            o_gen_word[g] = w;
            state_next[g] = s;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            state <= PRBS_SEEDS;
        else if (i_clear)
            state <= PRBS_SEEDS;
        else if (i_advance)
            state <= state_next; // Whole word per cycle
    end

    // Lock-up would mean a broken feedback path
    for (genvar g = 0; g < NUM_GEN_LANES; g++) begin : g_no_lockup
        assert property (@(posedge i_clk) disable iff (!i_rst_n) state[g] != '0);
    end

endmodule

// File: hw/lane_mapper.sv
module lane_mapper
    import lfsr_tx_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  tx_lanes_e  i_lanes,
    input  logic       i_send_pattern,
    input  logic       i_send_id,
    input  logic       i_reversed,
    input  lane_word_t i_gen_word [NUM_GEN_LANES],
    output lane_word_t o_lane [NUM_TX_LANES]
);

    logic       lo_on;
    logic       hi_on;
    lane_word_t lane_next [NUM_TX_LANES];

    assign lo_on = (i_lanes == LANES_0_7) || (i_lanes == LANES_0_15);
    assign hi_on = (i_lanes == LANES_8_15) || (i_lanes == LANES_0_15);

    // Marker, 8-bit id, marker, sent twice
    function automatic lane_word_t id_word(input lane_idx_t id);
        logic [15:0] group;
        group = {LANE_ID_MARK, 8'(id), LANE_ID_MARK};
        return {group, group};
    endfunction

    always_comb begin
        lane_idx_t n_idx;
        lane_idx_t src;
        logic      on;
        for (int n = 0; n < NUM_TX_LANES; n++) begin
            n_idx = lane_idx_t'(n);
            // Inverting the index gives 15-n, and 7-j in its low three bits
            src = i_reversed ? ~n_idx : n_idx;
            on  = n_idx[3] ? hi_on : lo_on;
            if (on && i_send_pattern)
                lane_next[n] = i_gen_word[src[2:0]]; // Both halves share generators
            else if (on && i_send_id)
                lane_next[n] = id_word(src);
            else
                lane_next[n] = '0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_lane <= '{default: '0};
        else
            o_lane <= lane_next;
    end

    // Pattern and identifier runs come from separate FSM states
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_send_pattern && i_send_id));

endmodule

// File: hw/lfsr_tx_top.sv
module lfsr_tx_top
    import lfsr_tx_pkg::*;
#(
    parameter int PATTERN_WORDS = 127,
    parameter int LANE_ID_WORDS = 63
)(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  tx_cmd_e    i_cmd,
    input  tx_lanes_e  i_lanes,
    input  logic       i_enable_reversal,
    output lane_word_t o_lane [NUM_TX_LANES],
    output logic       o_tx_done,
    output logic       o_enable_frame
);

    logic       gen_clear;
    logic       gen_advance;
    logic       send_pattern;
    logic       send_id;
    logic       reversed;
    lane_word_t gen_word [NUM_GEN_LANES];

    lfsr_tx_ctrl #(
        .PATTERN_WORDS (PATTERN_WORDS),
        .LANE_ID_WORDS (LANE_ID_WORDS)
    ) u_ctrl (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_cmd             (i_cmd),
        .i_lanes           (i_lanes),
        .i_enable_reversal (i_enable_reversal),
        .o_gen_clear       (gen_clear),
        .o_gen_advance     (gen_advance),
        .o_send_pattern    (send_pattern),
        .o_send_id         (send_id),
        .o_reversed        (reversed),
        .o_tx_done         (o_tx_done),
        .o_enable_frame    (o_enable_frame)
    );

    prbs23_lane_gen u_gen (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_clear    (gen_clear),
        .i_advance  (gen_advance),
        .o_gen_word (gen_word)
    );

    lane_mapper u_mapper (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_lanes        (i_lanes),
        .i_send_pattern (send_pattern),
        .i_send_id      (send_id),
        .i_reversed     (reversed),
        .i_gen_word     (gen_word),
        .o_lane         (o_lane)
    );

endmodule

// File: verification/lfsr_tx_tb.sv
module lfsr_tx_tb
    import lfsr_tx_pkg::*;
;

    logic       i_clk;
    logic       i_rst_n;
    tx_cmd_e    i_cmd;
    tx_lanes_e  i_lanes;
    logic       i_enable_reversal;
    lane_word_t o_lane [NUM_TX_LANES];
    logic       o_tx_done;
    logic       o_enable_frame;

    // Runs from the stimulus file
    int run_cmd[$];
    int run_lanes[$];
    int run_rev[$];
    int run_words[$];

    int cycle_count;
    int cycle_limit;

    // Reference model state
    prbs_state_t model_state [NUM_GEN_LANES];
    lane_word_t  model_word  [NUM_GEN_LANES];
    logic        rev_model;
    int          lanes_model;

    lfsr_tx_top UUT (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_cmd             (i_cmd),
        .i_lanes           (i_lanes),
        .i_enable_reversal (i_enable_reversal),
        .o_lane            (o_lane),
        .o_tx_done         (o_tx_done),
        .o_enable_frame    (o_enable_frame)
    );

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
            abort_run($sformatf("Timeout, the test did not end within %0d cycles", cycle_limit));
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input lane_word_t exp, input lane_word_t act);
        assert (act === exp) else
            abort_run($sformatf("ERROR: time %0t %s expected %h actual %h",
                                $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act === exp) else
            abort_run($sformatf("ERROR: time %0t %s expected %b actual %b",
                                $time, name, exp, act));
    endtask

    task automatic reset_model();
        for (int g = 0; g < NUM_GEN_LANES; g++)
            model_state[g] = PRBS_SEEDS[g];
    endtask

    // One word per generator, taps from x^23 + x^21 + x^16 + x^8 + x^5 + x^2 + 1
    task automatic advance_model();
        prbs_state_t s;
        lane_word_t  w;
        logic        fb;
        for (int g = 0; g < NUM_GEN_LANES; g++) begin
            s = model_state[g];
            w = '0;
            for (int b = 0; b < 32; b++) begin
                fb   = s[22] ^ s[20] ^ s[15] ^ s[7] ^ s[4] ^ s[1];
                w[b] = fb;
                s    = {s[21:0], fb};
            end
            model_word[g]  = w;
            model_state[g] = s;
        end
    endtask

    function automatic logic lane_active(input int n);
        case (lanes_model)
            1:       return n < 8;
            2:       return n >= 8;
            3:       return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Mode 0 idle, 1 pattern, 2 lane id
    function automatic lane_word_t expected_lane(input int n, input int mode);
        int         src;
        logic [7:0] id8;
        src = rev_model ? 15 - n : n;
        id8 = 8'(src);
        if (mode == 0 || !lane_active(n))
            return '0;
        if (mode == 1)
            return model_word[src % 8];
        return {LANE_ID_MARK, id8, LANE_ID_MARK, LANE_ID_MARK, id8, LANE_ID_MARK};
    endfunction

    task automatic check_all_lanes(input int mode);
        for (int n = 0; n < NUM_TX_LANES; n++)
            check_word($sformatf("o_lane[%0d]", n), expected_lane(n, mode), o_lane[n]);
    endtask

    task automatic check_quiet();
        check_bit("o_tx_done", 1'b0, o_tx_done);
        check_bit("o_enable_frame", 1'b0, o_enable_frame);
        check_all_lanes(0);
    endtask

    task automatic do_clear();
        @(negedge i_clk);
        @(negedge i_clk);   // After edge k, FSM in ST_CLEAR
        @(negedge i_clk);   // Seeds reloaded at k+1
        reset_model();
        check_quiet();
    endtask

    task automatic send_frame(input int mode, input int words);
        @(negedge i_clk);
        @(negedge i_clk);   // After edge k
        check_quiet();
        for (int w = 0; w < words; w++) begin
            if (mode == 1)
                advance_model();
            @(negedge i_clk);
            check_bit("o_enable_frame", 1'b1, o_enable_frame);
            check_bit("o_tx_done", 1'b0, o_tx_done);
            check_all_lanes(mode);
        end
        if (mode == 1)
            advance_model(); // Last generated word is never sent
        @(negedge i_clk);
        check_bit("o_tx_done", 1'b1, o_tx_done);
        check_bit("o_enable_frame", 1'b0, o_enable_frame);
        check_all_lanes(0);
        @(negedge i_clk);
        check_quiet();      // Done is a single pulse
    endtask

    task automatic ignored_command();
        repeat (140) begin
            @(negedge i_clk);
            check_quiet();
        end
    endtask

    initial begin
        int    fd;
        int    cnt;
        int    cmd_v;
        int    lanes_v;
        int    rev_v;
        int    words_v;
        string line;

        i_clk             = 1'b0;
        i_rst_n           = 1'b0;
        i_cmd             = CMD_IDLE;
        i_lanes           = LANES_NONE;
        i_enable_reversal = 1'b0;
        cycle_count       = 0;
        cycle_limit       = 50;
        rev_model         = 1'b0;
        lanes_model       = 0;
        reset_model();

        fd = $fopen("verification/lfsr_tx_stimulus.txt", "r");
        if (fd == 0)
            abort_run("Could not open the stimulus file");
        while (!$feof(fd)) begin
            cnt = $fgets(line, fd);
            if (cnt > 0 && line.getc(0) != "#") begin
                if ($sscanf(line, "%d %d %d %d", cmd_v, lanes_v, rev_v, words_v) == 4) begin
                    run_cmd.push_back(cmd_v);
                    run_lanes.push_back(lanes_v);
                    run_rev.push_back(rev_v);
                    run_words.push_back(words_v);
                end
            end
        end
        $fclose(fd);
        cycle_limit = 130 * run_cmd.size() + 50;

        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_quiet();

        for (int i = 0; i < run_cmd.size(); i++) begin
            if (run_rev[i] != 0)
                rev_model = 1'b1; // Latched while idle, held until reset
            lanes_model = run_lanes[i];
            @(posedge i_clk);
            i_cmd             <= tx_cmd_e'(2'(run_cmd[i]));
            i_lanes           <= tx_lanes_e'(2'(run_lanes[i]));
            i_enable_reversal <= (run_rev[i] != 0);
            if (run_lanes[i] == 0)
                ignored_command();
            else if (run_cmd[i] == 1)
                do_clear();
            else
                send_frame((run_cmd[i] == 2) ? 1 : 2, run_words[i]);
            @(posedge i_clk);
            i_cmd             <= CMD_IDLE; // Next command must be a fresh edge
            i_enable_reversal <= 1'b0;
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: verification/lfsr_tx_stimulus.txt
# Columns: cmd lanes rev words (cmd 1 clear, 2 pattern, 3 lane id; lanes 0 none, 1 0-7, 2 8-15, 3 all)
# words is the expected frame length, 0 where no frame is sent
1 3 0 0
2 3 0 127
2 1 0 127
2 2 0 127
1 3 0 0
2 3 0 127
3 3 0 63
3 1 1 63
2 3 0 127
3 2 0 63
2 0 0 0
1 3 0 0
2 2 0 127
3 3 0 63

// File: verilog.f
hw/lfsr_tx_pkg.sv
hw/lfsr_tx_ctrl.sv
hw/prbs23_lane_gen.sv
hw/lane_mapper.sv
hw/lfsr_tx_top.sv
verification/lfsr_tx_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module lfsr_tx_tb -f verilog.f -o lfsr_tx_sim \
    > sim.log 2>&1 \
    && ./obj_dir/lfsr_tx_sim >> sim.log 2>&1
cat sim.log
! grep -q "Simulation FAILED" sim.log && grep -q "Simulation PASSED" sim.log \
    && echo "Run passed" \
    || { echo "Run failed, see sim.log"; exit 1; }
